// ==== tb.f ====
lock_pkg.sv
param_bank.sv
lock_scaler.sv
lock_integrator.sv
dac_formatter.sv
output_preprocessor_top.sv
output_preprocessor_chk.sv
tb_output_preprocessor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_output_preprocessor -o tb_sim > build.log 2>&1 \
	|| { echo "verilator build failed"; cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0

// ==== tb_output_preprocessor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_output_preprocessor;

	import lock_pkg::*;

	localparam int DRAIN_TIMEOUT = 200;	// cycles allowed for the pipeline to empty
	localparam int LATENCY       = 3;	// drive edge to observe edge, in periods

	logic               clk_in;
	logic               reset_in;
	logic signed [17:0] data_in;	// default W_IN
	logic               data_valid_in;
	logic               lock_en_in;
	sample_t            output_max_in;
	sample_t            output_min_in;
	sample_t            output_init_in;
	mult_t              multiplier_in;
	logic               update_en_in;
	logic               update_in;
	dac_word_t          data_out;
	logic               data_valid_out;

	sample_t   m_max, m_min, m_init, m_prev;	// reference model state
	mult_t     m_mult;
	dac_word_t exp_data[$];	// expected words in order
	int        exp_cycle[$];	// cycle each word must appear in
	dac_word_t last_out;	// most recent word seen
	int        cycle_cnt = 0;
	integer    seed;

	output_preprocessor_top output_preprocessor_top_inst (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.data_in        (data_in),
		.data_valid_in  (data_valid_in),
		.lock_en_in     (lock_en_in),
		.output_max_in  (output_max_in),
		.output_min_in  (output_min_in),
		.output_init_in (output_init_in),
		.multiplier_in  (multiplier_in),
		.update_en_in   (update_en_in),
		.update_in      (update_in),
		.data_out       (data_out),
		.data_valid_out (data_valid_out)
	);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in;	// 8 ns period
	end

	always @(posedge clk_in) cycle_cnt <= cycle_cnt + 1;

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int saturate16(input int v);
		if (v > 32767) return 32767;
		if (v < -32768) return -32768;
		return v;
	endfunction

	function automatic sample_t model_step(input logic signed [17:0] din, input logic lock);
		int v;
		v = saturate16((int'(din) >>> 2) * int'(m_mult));	// top 16 bits times gain
		v = saturate16(v + int'(m_prev));	// accumulate, no wrap
		if (!lock) v = int'(m_init);	// unlocked parks at init
		if (v > int'(m_max)) v = int'(m_max);
		if (v < int'(m_min)) v = int'(m_min);	// min applied last
		return sample_t'(v);
	endfunction

	function automatic dac_word_t to_dac(input sample_t s);
		return dac_word_t'(int'(s) + 32768);	// offset binary, zero at most negative
	endfunction

	// reference state right after a reset
	task automatic model_defaults;
		m_max  = 16'sd9999;	// reset parameter set
		m_min  = 16'sd1111;
		m_init = 16'sd5000;
		m_prev = 16'sd5000;
		m_mult = 8'd1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// failure reporting and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("SOME TESTS FAILED");
		$display("%s", reason);
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk_in) begin
		if (!reset_in && data_valid_out) begin
			if (exp_data.size() == 0) begin
				abort_run("data_valid_out went high with no sample pending");
			end
			check_value("data_out", data_out, exp_data.pop_front());
			check_value("output cycle", cycle_cnt, exp_cycle.pop_front());
			last_out = data_out;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic send_sample(input logic signed [17:0] din, input logic lock);
		@(negedge clk_in);
		data_in       = din;
		data_valid_in = 1'b1;
		lock_en_in    = lock;
		m_prev        = model_step(din, lock);	// every valid sample feeds back
		exp_data.push_back(to_dac(m_prev));
		exp_cycle.push_back(cycle_cnt + LATENCY);
	endtask

	task automatic go_idle;
		@(negedge clk_in);
		data_valid_in = 1'b0;
	endtask

	task automatic wait_drain;
		int t;
		t = 0;
		while (exp_data.size() != 0) begin
			@(negedge clk_in);
			t++;
			if (t > DRAIN_TIMEOUT) abort_run("timeout waiting for data_valid_out");
		end
	endtask

	// pipeline must be empty, capture edge then reload edge
	task automatic load_params(input sample_t mx, input sample_t mn, input sample_t ini,
			input mult_t mu, input logic en);
		@(negedge clk_in);
		output_max_in  = mx;
		output_min_in  = mn;
		output_init_in = ini;
		multiplier_in  = mu;
		update_en_in   = en;
		update_in      = 1'b1;
		@(negedge clk_in);
		update_in    = 1'b0;
		update_en_in = 1'b0;
		if (en) begin
			m_max  = mx;
			m_min  = mn;
			m_init = ini;
			m_mult = mu;
			m_prev = ini;	// reload restarts the integrator
		end
		@(negedge clk_in);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_defaults;
		send_sample(18'sd1234, 1'b0);	// unlocked, value ignored
		go_idle();
		wait_drain();
		check_value("data_out", last_out, 32'h9388);	// 5000 as offset binary
	endtask

	task automatic accumulate_run;
		send_sample(18'sd400, 1'b1);	// +100
		send_sample(18'sd800, 1'b1);	// +200, back to back
		go_idle();
		send_sample(-18'sd120, 1'b1);	// -30
		send_sample(18'sd3, 1'b1);	// low bits dropped, +0
		send_sample(-18'sd1, 1'b1);	// -1 after shift
		go_idle();
		wait_drain();
		check_value("data_out", last_out, to_dac(16'sd5269));
	endtask

	task automatic saturate_and_clamp;
		load_params(16'sd30000, -16'sd30000, 16'sd0, 8'd200, 1'b1);
		send_sample(18'sd131071, 1'b1);	// product saturates
		send_sample(18'sd131071, 1'b1);	// sum overflows 16 bits
		go_idle();
		wait_drain();
		check_value("data_out", last_out, to_dac(16'sd30000));
		send_sample(-18'sd131072, 1'b1);
		send_sample(-18'sd131072, 1'b1);
		send_sample(-18'sd131072, 1'b1);	// would wrap positive
		go_idle();
		wait_drain();
		check_value("data_out", last_out, to_dac(-16'sd30000));
	endtask

	task automatic param_update;
		load_params(16'sd100, -16'sd100, 16'sd50, 8'd7, 1'b0);	// disarmed strobe
		send_sample(18'sd40, 1'b1);
		go_idle();
		wait_drain();
		check_value("data_out", last_out, to_dac(-16'sd28000));	// old gain and prev
		load_params(16'sd12000, -16'sd12000, 16'sd100, 8'd3, 1'b1);
		send_sample(18'sd400, 1'b1);
		go_idle();
		wait_drain();
		check_value("data_out", last_out, to_dac(16'sd400));	// from new init
	endtask

	task automatic random_stream;
		logic [31:0] r;
		logic signed [17:0] din;
		for (int i = 0; i < 50; i++) begin
			r   = $random(seed);
			din = r[17:0];
			if (r[31]) din = din >>> 6;	// mix in small values
			send_sample(din, r[24] | r[25]);	// mostly locked
		end
		go_idle();
		wait_drain();
	endtask

	task automatic midstream_reset;
		send_sample(18'sd4000, 1'b1);
		send_sample(18'sd4000, 1'b1);	// both still in flight
		@(negedge clk_in);
		data_valid_in = 1'b0;
		reset_in      = 1'b1;	// flushes the pipeline and the settings
		exp_data.delete();
		exp_cycle.delete();
		model_defaults();
		repeat (10) @(negedge clk_in);
		reset_in = 1'b0;
		send_sample(18'sd400, 1'b1);	// +100 onto the reset value
		go_idle();
		wait_drain();
		check_value("data_out", last_out, to_dac(16'sd5100));
	endtask

	initial begin
		seed           = 26578;
		reset_in       = 1'b1;
		data_in        = '0;
		data_valid_in  = 1'b0;
		lock_en_in     = 1'b0;
		output_max_in  = '0;
		output_min_in  = '0;
		output_init_in = '0;
		multiplier_in  = '0;
		update_en_in   = 1'b0;
		update_in      = 1'b0;
		last_out       = '0;
		model_defaults();
		repeat (10) @(negedge clk_in);
		reset_in = 1'b0;
		reset_defaults();
		accumulate_run();
		saturate_and_clamp();
		param_update();
		random_stream();
		midstream_reset();
		repeat (5) @(negedge clk_in);	// catch stray strobes
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== output_preprocessor_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor_chk (
	input wire clk_in,	// system clock
	input wire reset_in,	// sync reset, active high
	input wire data_valid_in,	// input strobe
	input wire data_valid_out	// output strobe
);

	////////////////////////////////////////////////////////////////////////////
	// strobe timing
	////////////////////////////////////////////////////////////////////////////

	// three registers between the strobes, checked once reset has flushed them
	property valid_delay_p;
		@(posedge clk_in) disable iff (reset_in)
		(!$past(reset_in, 1) && !$past(reset_in, 2) && !$past(reset_in, 3))
			|-> (data_valid_out == $past(data_valid_in, 3));
	endproperty

	property reset_clears_valid_p;
		@(posedge clk_in) reset_in |=> !data_valid_out;	// cleared on the reset edge
	endproperty

	valid_delay_a : assert property (valid_delay_p)
		else $error("data_valid_out is not data_valid_in delayed by three cycles");

	reset_clears_valid_a : assert property (reset_clears_valid_p)
		else $error("data_valid_out high in the cycle after reset");

endmodule

bind output_preprocessor_top output_preprocessor_chk output_preprocessor_chk_inst (
	.clk_in         (clk_in),
	.reset_in       (reset_in),
	.data_valid_in  (data_valid_in),
	.data_valid_out (data_valid_out)
);

`default_nettype wire

// ==== output_preprocessor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor_top #(
	parameter int W_IN      = 18,	// input sample width
	parameter int OMAX_INIT = 9999,	// reset upper bound
	parameter int OMIN_INIT = 1111,	// reset lower bound
	parameter int OUT_INIT  = 5000,	// reset initial output
	parameter int MULT_INIT = 1	// reset gain
) (
	input  wire                 clk_in,	// system clock
	input  wire                 reset_in,	// sync reset, active high

	// from the input mux
	input  wire signed [W_IN-1:0] data_in,	// error sample
	input  wire                 data_valid_in,	// sample strobe
	input  wire                 lock_en_in,	// lock enable

	// front panel
	input  lock_pkg::sample_t   output_max_in,	// upper bound
	input  lock_pkg::sample_t   output_min_in,	// lower bound
	input  lock_pkg::sample_t   output_init_in,	// initial output
	input  lock_pkg::mult_t     multiplier_in,	// gain
	input  wire                 update_en_in,	// update arm
	input  wire                 update_in,	// update strobe

	// to dds controller or dac queue
	output lock_pkg::dac_word_t data_out,	// offset binary code
	output wire                 data_valid_out	// output strobe
);

	import lock_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////////////////////

	out_params_t params;	// active settings
	logic        reload;	// restart pulse after a capture
	stage_t      scaled;	// stage 1 to stage 2
	stage_t      limited;	// stage 2 to stage 3

	////////////////////////////////////////////////////////////////////////////
	// parameter bank
	////////////////////////////////////////////////////////////////////////////

	param_bank #(
		.OMAX_INIT (OMAX_INIT),
		.OMIN_INIT (OMIN_INIT),
		.OUT_INIT  (OUT_INIT),
		.MULT_INIT (MULT_INIT)
	) param_bank_inst (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.output_max_in  (output_max_in),
		.output_min_in  (output_min_in),
		.output_init_in (output_init_in),
		.multiplier_in  (multiplier_in),
		.update_en_in   (update_en_in),
		.update_in      (update_in),
		.params         (params),
		.reload         (reload)
	);

	////////////////////////////////////////////////////////////////////////////
	// three stage pipeline
	////////////////////////////////////////////////////////////////////////////

	lock_scaler #(
		.W_IN (W_IN)
	) lock_scaler_inst (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.data_in       (data_in),
		.data_valid_in (data_valid_in),
		.lock_en_in    (lock_en_in),
		.params        (params),
		.scaled        (scaled)
	);

	lock_integrator #(
		.OUT_INIT (OUT_INIT)	// must match the bank reset value
	) lock_integrator_inst (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.scaled   (scaled),
		.params   (params),
		.reload   (reload),
		.limited  (limited)
	);

	dac_formatter dac_formatter_inst (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.limited        (limited),
		.data_out       (data_out),
		.data_valid_out (data_valid_out)
	);

endmodule

`default_nettype wire

// ==== dac_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_formatter (
	input  wire                clk_in,	// system clock
	input  wire                reset_in,	// sync reset, active high

	input  lock_pkg::stage_t   limited,	// stage 2 result

	// to dds controller or dac queue
	output lock_pkg::dac_word_t data_out,	// offset binary code
	output logic               data_valid_out	// output strobe
);

	import lock_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// offset binary conversion
	////////////////////////////////////////////////////////////////////////////

	dac_word_t dac_code;	// unregistered code

	// msb flip maps SAMPLE_MIN to zero and SAMPLE_MAX to full scale
	assign dac_code = {~limited.data[OUT_W-1], limited.data[OUT_W-2:0]};

	////////////////////////////////////////////////////////////////////////////
	// stage 3 register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		data_out <= dac_code;	// no reset on the data word
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_valid_out <= 1'b0;	// nothing in flight after reset
		end else begin
			data_valid_out <= limited.valid;
		end
	end

endmodule

`default_nettype wire

// ==== lock_integrator.sv ====
`timescale 1ns/1ps
`default_nettype none

module lock_integrator #(
	parameter int OUT_INIT = 5000	// previous output after reset
) (
	input  wire                  clk_in,	// system clock
	input  wire                  reset_in,	// sync reset, active high

	input  lock_pkg::stage_t     scaled,	// stage 1 result
	input  lock_pkg::out_params_t params,	// active settings
	input  wire                  reload,	// restart from output_init

	output lock_pkg::stage_t     limited	// stage 2 result
);

	import lock_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// accumulation
	////////////////////////////////////////////////////////////////////////////

	sample_t                prev_q;	// last output that went out
	logic signed [OUT_W:0]  sum_full;	// one guard bit
	logic                   sum_ovf;	// guard and sign bit disagree
	sample_t                sum_sat;	// saturated sum

	assign sum_full = scaled.data + prev_q;	// both sign extended
	assign sum_ovf  = sum_full[OUT_W] != sum_full[OUT_W-1];

	always_comb begin
		if (sum_ovf) begin
			// guard bit holds the true sign
			sum_sat = sum_full[OUT_W] ? SAMPLE_MIN : SAMPLE_MAX;
		end else begin
			sum_sat = sum_full[OUT_W-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// lock disable and bounds
	////////////////////////////////////////////////////////////////////////////

	sample_t held;	// after unlock substitution
	sample_t upper;	// after max clamp
	sample_t result;	// after min clamp

	// unlocked output parks at the initial value
	assign held = scaled.lock_en ? sum_sat : params.output_init;

	always_comb begin
		if (held > params.output_max) begin
			upper = params.output_max;	// max first
		end else begin
			upper = held;
		end
	end

	always_comb begin
		if (upper < params.output_min) begin
			result = params.output_min;	// min wins if bounds cross
		end else begin
			result = upper;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// previous output register
	////////////////////////////////////////////////////////////////////////////

	// a sample seen together with reload uses the old value,
	// reload then overwrites whatever the sample would have left
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev_q <= sample_t'(OUT_INIT);
		end else if (reload) begin
			prev_q <= params.output_init;	// new set just captured
		end else if (scaled.valid) begin
			prev_q <= result;	// feedback, ready for next cycle
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2 register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			limited.valid <= 1'b0;
		end else begin
			limited.valid <= scaled.valid;
		end
		limited.lock_en <= scaled.lock_en;	// carried along
		limited.data    <= result;
	end

endmodule

`default_nettype wire

// ==== lock_scaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module lock_scaler #(
	parameter int W_IN = 18	// input sample width
) (
	input  wire                  clk_in,	// system clock
	input  wire                  reset_in,	// sync reset, active high

	// from the input mux
	input  wire signed [W_IN-1:0] data_in,	// error sample
	input  wire                  data_valid_in,	// sample strobe
	input  wire                  lock_en_in,	// lock enable, travels with sample

	input  lock_pkg::out_params_t params,	// active settings, gain used here

	output lock_pkg::stage_t     scaled	// stage 1 result
);

	import lock_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// width conversion
	////////////////////////////////////////////////////////////////////////////

	sample_t narrow;	// input at output width

	generate
		if (W_IN >= OUT_W) begin : g_truncate
			// keep the msbs, lsbs dropped
			assign narrow = data_in[W_IN-1 -: OUT_W];
		end else begin : g_extend
			// short input, sign extended by the signed cast
			assign narrow = sample_t'(data_in);
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// gain and saturation
	////////////////////////////////////////////////////////////////////////////

	logic signed [OUT_W+MULT_W:0] product;	// full precision, never wraps
	sample_t                      product_sat;	// clipped to sample range

	// gain is unsigned, zero extended so the multiply stays signed
	assign product = narrow * $signed({1'b0, params.multiplier});

	always_comb begin
		if (product > SAMPLE_MAX) begin
			product_sat = SAMPLE_MAX;	// positive overflow
		end else if (product < SAMPLE_MIN) begin
			product_sat = SAMPLE_MIN;	// negative overflow
		end else begin
			product_sat = product[OUT_W-1:0];	// in range, low bits exact
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 1 register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			scaled.valid <= 1'b0;	// pipeline empty after reset
		end else begin
			scaled.valid <= data_valid_in;
		end
		scaled.lock_en <= lock_en_in;	// loaded every cycle
		scaled.data    <= product_sat;
	end

endmodule

`default_nettype wire

// ==== param_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_bank #(
	parameter int OMAX_INIT = 9999,	// reset upper bound
	parameter int OMIN_INIT = 1111,	// reset lower bound
	parameter int OUT_INIT  = 5000,	// reset initial output
	parameter int MULT_INIT = 1	// reset gain
) (
	input  wire                  clk_in,	// system clock
	input  wire                  reset_in,	// sync reset, active high

	// front panel inputs
	input  lock_pkg::sample_t    output_max_in,	// new upper bound
	input  lock_pkg::sample_t    output_min_in,	// new lower bound
	input  lock_pkg::sample_t    output_init_in,	// new initial output
	input  lock_pkg::mult_t      multiplier_in,	// new gain
	input  wire                  update_en_in,	// arms the update strobe
	input  wire                  update_in,	// capture strobe

	// to the pipeline
	output lock_pkg::out_params_t params,	// active parameter set
	output logic                 reload	// one cycle, after a capture
);

	import lock_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// capture qualifier
	////////////////////////////////////////////////////////////////////////////

	logic capture;	// strobe accepted this cycle

	assign capture = update_in & update_en_in;	// strobe ignored while disarmed

	////////////////////////////////////////////////////////////////////////////
	// active parameter registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			params.output_max  <= sample_t'(OMAX_INIT);	// power-up settings
			params.output_min  <= sample_t'(OMIN_INIT);
			params.output_init <= sample_t'(OUT_INIT);
			params.multiplier  <= mult_t'(MULT_INIT);
		end else if (capture) begin
			params.output_max  <= output_max_in;	// all four taken together
			params.output_min  <= output_min_in;
			params.output_init <= output_init_in;
			params.multiplier  <= multiplier_in;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reload pulse
	////////////////////////////////////////////////////////////////////////////

	// high in the cycle the new set becomes visible,
	// integrator restarts from the new initial value on the next edge
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			reload <= 1'b0;
		end else begin
			reload <= capture;	// single cycle for a single cycle strobe
		end
	end

endmodule

`default_nettype wire

// ==== lock_pkg.sv ====
`default_nettype none

package lock_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int OUT_W  = 16;	// dac word width, fixed by the converter
	localparam int MULT_W = 8;	// front panel gain width

	////////////////////////////////////////////////////////////////////////////
	// scalar types
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [OUT_W-1:0] sample_t;	// two's complement output sample
	typedef logic        [OUT_W-1:0] dac_word_t;	// offset binary dac code
	typedef logic       [MULT_W-1:0] mult_t;	// unsigned gain factor

	// saturation limits of one sample
	localparam sample_t SAMPLE_MAX = {1'b0, {(OUT_W-1){1'b1}}};	// 0x7fff
	localparam sample_t SAMPLE_MIN = {1'b1, {(OUT_W-1){1'b0}}};	// 0x8000

	////////////////////////////////////////////////////////////////////////////
	// front panel parameter set
	////////////////////////////////////////////////////////////////////////////

	// active settings, loaded as one word on an update
	typedef struct packed {
		sample_t output_max;	// upper clamp
		sample_t output_min;	// lower clamp
		sample_t output_init;	// value while unlocked, reload value
		mult_t   multiplier;	// gain applied in stage 1
	} out_params_t;

	////////////////////////////////////////////////////////////////////////////
	// pipeline stage word
	////////////////////////////////////////////////////////////////////////////

	// one sample plus its qualifiers, registered between stages
	typedef struct packed {
		logic    valid;	// sample strobe
		logic    lock_en;	// lock state captured with the sample
		sample_t data;	// sample value
	} stage_t;

	// every stage register holds one of these words
	// a stage with valid low still shifts, the content is ignored downstream

endpackage

`default_nettype wire
